// File: logic/fetch_pkg.sv
package fetch_pkg;

	// Basic datapath widths
	localparam int WORD_BITS = 32;
	localparam int TAG_BITS = 4;

	// Opcode field sits in the top six bits of the instruction
	localparam int OPCODE_BITS = 6;
	localparam int OPCODE_LSB = WORD_BITS - OPCODE_BITS;

	// Direct-mapped geometry with one word per line
	localparam int ICACHE_OFFSET_BITS = 2;
	localparam int ICACHE_INDEX_BITS = 4;
	localparam int ICACHE_LINES = 1 << ICACHE_INDEX_BITS;
	localparam int ICACHE_TAG_BITS = WORD_BITS - ICACHE_INDEX_BITS - ICACHE_OFFSET_BITS;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [OPCODE_BITS-1:0] opcode_t;
	typedef logic [ICACHE_INDEX_BITS-1:0] line_index_t;
	typedef logic [ICACHE_TAG_BITS-1:0] line_tag_t;

	// The only two opcodes the fetch stage has to recognize
	localparam opcode_t OPCODE_JUMP = 6'h02;
	localparam opcode_t OPCODE_BRANCH = 6'h04;

	localparam word_t RESET_PC = '0;

	typedef enum logic [1:0] {
		FETCH_REQUEST,
		FETCH_WAIT,
		BRANCH_WAIT
	} fetch_state_t;

	// Issued bundle towards decode
	typedef struct packed {
		tag_t tag;
		word_t pc;
		word_t instruction;
	} fetch_out_t;

	// Sent back by execute once a branch resolves
	typedef struct packed {
		tag_t tag;
		word_t pc_next;
	} redirect_t;

	// Cache answer that is valid once its tag equals the request tag
	typedef struct packed {
		tag_t tag;
		word_t rdata;
	} icache_reply_t;

endpackage

// File: logic/icache.sv
`timescale 1ns/10ps

module icache (
	input logic i_clock,
	input logic i_reset,

	// Fetch side
	input fetch_pkg::tag_t i_request_tag,
	input fetch_pkg::word_t i_address,
	output fetch_pkg::icache_reply_t o_reply,

	// Read-only word bus
	output logic o_bus_request,
	input logic i_bus_ready,
	output fetch_pkg::word_t o_bus_address,
	input fetch_pkg::word_t i_bus_rdata,

	// Debug counters
	output fetch_pkg::word_t o_hit_count,
	output fetch_pkg::word_t o_miss_count
);

	typedef enum logic {
		CACHE_IDLE,
		CACHE_REFILL
	} cache_state_t;

	cache_state_t state;

	// Last request tag that was looked up
	fetch_pkg::tag_t seen_tag;

	// Line storage
	logic [fetch_pkg::ICACHE_LINES-1:0] line_valid;
	fetch_pkg::line_tag_t line_tag [fetch_pkg::ICACHE_LINES];
	fetch_pkg::word_t line_data [fetch_pkg::ICACHE_LINES];

	fetch_pkg::line_index_t lookup_index;
	fetch_pkg::line_tag_t lookup_tag;
	fetch_pkg::line_index_t fill_index;
	fetch_pkg::line_tag_t fill_tag;
	logic new_request;
	logic lookup_hit;
	logic fill_done;

	// Address split for the lookup
	assign lookup_index = i_address[fetch_pkg::ICACHE_OFFSET_BITS +: fetch_pkg::ICACHE_INDEX_BITS];
	assign lookup_tag = i_address[fetch_pkg::WORD_BITS-1 -: fetch_pkg::ICACHE_TAG_BITS];

	// Fill goes to the line of the address held on the bus
	assign fill_index =
		o_bus_address[fetch_pkg::ICACHE_OFFSET_BITS +: fetch_pkg::ICACHE_INDEX_BITS];
	assign fill_tag = o_bus_address[fetch_pkg::WORD_BITS-1 -: fetch_pkg::ICACHE_TAG_BITS];

	// A lookup starts whenever the fetch unit moves its tag
	assign new_request = (state == CACHE_IDLE) && (i_request_tag != seen_tag);
	assign lookup_hit = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);
	assign fill_done = (state == CACHE_REFILL) && i_bus_ready;

	always_ff @(posedge i_clock) begin
		if (fill_done) begin
			line_tag[fill_index] <= fill_tag;
			line_data[fill_index] <= i_bus_rdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CACHE_IDLE;
			seen_tag <= '0;
			line_valid <= '0;
			o_reply <= '0;
			o_bus_request <= 1'b0;
			o_bus_address <= '0;
			o_hit_count <= '0;
			o_miss_count <= '0;
		end else begin
			case (state)
				CACHE_IDLE: begin
					if (new_request) begin
						seen_tag <= i_request_tag;
						if (lookup_hit) begin
							// Hit answers on the next cycle
							o_reply <= '{tag: i_request_tag, rdata: line_data[lookup_index]};
							o_hit_count <= o_hit_count + 32'd1;
						end else begin
							// Go out to the bus on a miss and hold the address steady
							o_bus_request <= 1'b1;
							o_bus_address <= i_address;
							o_miss_count <= o_miss_count + 32'd1;
							state <= CACHE_REFILL;
						end
					end
				end

				CACHE_REFILL: begin
					if (i_bus_ready) begin
						line_valid[fill_index] <= 1'b1;
						// Forward the fetched word together with the fill
						o_reply <= '{tag: seen_tag, rdata: i_bus_rdata};
						o_bus_request <= 1'b0;
						state <= CACHE_IDLE;
					end
				end

				default: begin
					state <= CACHE_IDLE;
				end
			endcase
		end
	end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
	input logic i_clock,
	input logic i_reset,

	// Pipeline control
	input logic i_stall,
	input fetch_pkg::redirect_t i_redirect,

	// Cache side
	input fetch_pkg::icache_reply_t i_reply,
	output fetch_pkg::tag_t o_request_tag,
	output fetch_pkg::word_t o_address,

	// Issued instruction
	output fetch_pkg::fetch_out_t o_fetch
);

	fetch_pkg::fetch_state_t state;
	fetch_pkg::word_t pc;
	fetch_pkg::tag_t request_tag;

	fetch_pkg::opcode_t reply_opcode;
	logic reply_is_branch;
	logic reply_ready;
	logic redirect_match;
	fetch_pkg::tag_t next_tag;

	// Only the branch opcodes are decoded here
	assign reply_opcode = i_reply.rdata[fetch_pkg::OPCODE_LSB +: fetch_pkg::OPCODE_BITS];
	assign reply_is_branch = (reply_opcode == fetch_pkg::OPCODE_JUMP) ||
		(reply_opcode == fetch_pkg::OPCODE_BRANCH);

	// Reply belongs to the outstanding request
	assign reply_ready = (i_reply.tag == request_tag);

	// Execute answers with the tag of the branch it resolved
	assign redirect_match = (i_redirect.tag == o_fetch.tag);

	assign next_tag = request_tag + 1'b1;

	assign o_request_tag = request_tag;
	assign o_address = pc;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::FETCH_REQUEST;
			pc <= fetch_pkg::RESET_PC;
			request_tag <= '0;
			o_fetch <= '0;
		end else begin
			case (state)
				fetch_pkg::FETCH_REQUEST: begin
					// New tag starts a cache lookup at the current pc
					if (!i_stall) begin
						request_tag <= next_tag;
						state <= fetch_pkg::FETCH_WAIT;
					end
				end

				fetch_pkg::FETCH_WAIT: begin
					if (!i_stall && reply_ready) begin
						o_fetch <= '{
							tag: i_reply.tag,
							pc: pc,
							instruction: i_reply.rdata
						};
						pc <= pc + 32'd4;

						if (reply_is_branch) begin
							// Hold until execute tells us where to go
							state <= fetch_pkg::BRANCH_WAIT;
						end else begin
							// Request the next word straight away
							request_tag <= next_tag;
						end
					end
				end

				fetch_pkg::BRANCH_WAIT: begin
					if (redirect_match) begin
						pc <= i_redirect.pc_next;
						state <= fetch_pkg::FETCH_REQUEST;
					end
				end

				default: begin
					state <= fetch_pkg::FETCH_REQUEST;
				end
			endcase
		end
	end

endmodule

// File: logic/fetch_top.sv
`timescale 1ns/10ps

module fetch_top (
	input logic i_clock,
	input logic i_reset,

	// Pipeline ports
	input logic i_stall,
	input fetch_pkg::redirect_t i_redirect,
	output fetch_pkg::fetch_out_t o_fetch,

	// Word bus
	output logic o_bus_request,
	input logic i_bus_ready,
	output fetch_pkg::word_t o_bus_address,
	input fetch_pkg::word_t i_bus_rdata,

	// Debug
	output fetch_pkg::word_t o_hit_count,
	output fetch_pkg::word_t o_miss_count
);

	fetch_pkg::tag_t request_tag;
	fetch_pkg::word_t fetch_address;
	fetch_pkg::icache_reply_t cache_reply;

	fetch_unit u_fetch_unit (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.i_redirect(i_redirect),
		.i_reply(cache_reply),
		.o_request_tag(request_tag),
		.o_address(fetch_address),
		.o_fetch(o_fetch)
	);

	icache u_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request_tag(request_tag),
		.i_address(fetch_address),
		.o_reply(cache_reply),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata),
		.o_hit_count(o_hit_count),
		.o_miss_count(o_miss_count)
	);

endmodule

// File: test/fetch_assert.sv
`timescale 1ns/10ps

module fetch_assert (
	input logic i_clock,
	input logic i_reset,
	input logic i_bus_request,
	input logic i_bus_ready,
	input fetch_pkg::word_t i_bus_address,
	input fetch_pkg::word_t i_hit_count,
	input fetch_pkg::word_t i_miss_count
);

	// Address may only move when a new request starts
	address_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_request && $past(i_bus_request) |-> $stable(i_bus_address))
		else $error("bus address moved while the request was high");

	// Memory answers only an open request
	ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_ready |-> i_bus_request)
		else $error("bus ready seen without a request");

	hits_monotonic: assert property (@(posedge i_clock) disable iff (i_reset)
		i_hit_count >= $past(i_hit_count))
		else $error("hit counter went down");

	misses_monotonic: assert property (@(posedge i_clock) disable iff (i_reset)
		i_miss_count >= $past(i_miss_count))
		else $error("miss counter went down");

endmodule

bind icache fetch_assert u_fetch_assert (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_bus_request(o_bus_request),
	.i_bus_ready(i_bus_ready),
	.i_bus_address(o_bus_address),
	.i_hit_count(o_hit_count),
	.i_miss_count(o_miss_count)
);

// File: test/tb_fetch.sv
`timescale 1ns/10ps

module tb_fetch;

	// Layout of the data file image
	localparam int CFG_LATENCY = 0;
	localparam int CFG_STALL = 1;
	localparam int CFG_ISSUES = 2;
	localparam int CFG_DELAY = 3;
	localparam int CFG_REDIRECTS = 4;
	localparam int TARGET_BASE = 16;
	localparam int PC_BASE = 32;
	localparam int MEM_BASE = 64;
	localparam int MEM_WORDS = 64;

	logic i_clock = 1'b0;
	logic i_reset = 1'b1;
	logic i_stall = 1'b0;
	fetch_pkg::redirect_t i_redirect = '{tag: 4'h8, pc_next: 32'h0};
	logic i_bus_ready = 1'b0;
	fetch_pkg::word_t i_bus_rdata = '0;
	fetch_pkg::fetch_out_t o_fetch;
	logic o_bus_request;
	fetch_pkg::word_t o_bus_address;
	fetch_pkg::word_t o_hit_count;
	fetch_pkg::word_t o_miss_count;

	fetch_pkg::word_t testdata [0:MEM_BASE+MEM_WORDS-1];
	int error_count = 0;
	int issue_count = 0;
	int n_issues = 0;
	int bus_request_count = 0;

	// Values sampled on the falling edge
	fetch_pkg::fetch_out_t prev_fetch;
	logic prev_stall = 1'b0;
	logic prev_request = 1'b0;
	fetch_pkg::word_t sampled_address = '0;
	fetch_pkg::tag_t last_tag = '0;

	// Branch bookkeeping shared with the redirect driver
	int branches_seen = 0;
	int branches_served = 0;
	fetch_pkg::tag_t branch_tag = '0;
	fetch_pkg::word_t branch_target = '0;
	logic last_was_branch = 1'b0;
	fetch_pkg::word_t last_rule_pc = '0;

	// Reference cache model
	logic model_valid [16];
	logic [25:0] model_tag [16];
	int model_hits = 0;
	int model_misses = 0;

	fetch_top UUT (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.i_redirect(i_redirect),
		.o_fetch(o_fetch),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata),
		.o_hit_count(o_hit_count),
		.o_miss_count(o_miss_count)
	);

	always #50 i_clock = ~i_clock;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Program image and an address pattern beyond it
	function automatic fetch_pkg::word_t mem_word(input fetch_pkg::word_t address);
		if (address[31:8] == 24'h0)
			return testdata[MEM_BASE + int'(address[7:2])];
		return 32'hfc00_0000 ^ address;
	endfunction

	task automatic report_mismatch(input string name, input fetch_pkg::word_t expected,
		input fetch_pkg::word_t actual);
		error_count++;
		$display("error %s expected %h actual %h", name, expected, actual);
	endtask

	task automatic report_problem(input string text);
		error_count++;
		$display("%s", text);
	endtask

	task automatic check_issue();
		fetch_pkg::tag_t rule_tag;
		fetch_pkg::word_t rule_pc;
		fetch_pkg::word_t list_pc;
		fetch_pkg::word_t expected_word;
		logic [5:0] opcode;
		int model_index;
		if (issue_count >= n_issues) begin
			report_problem("an instruction was issued after the last expected one");
			return;
		end
		if (branches_served < branches_seen)
			report_problem("new instruction issued before the branch was redirected");

		// Tags count up from zero by one per issue
		rule_tag = fetch_pkg::tag_t'(issue_count + 1);
		if (issue_count == 0)
			rule_pc = fetch_pkg::RESET_PC;
		else if (last_was_branch)
			rule_pc = branch_target;
		else
			rule_pc = last_rule_pc + 32'd4;
		list_pc = testdata[PC_BASE + issue_count];
		expected_word = mem_word(list_pc);

		if (o_fetch.tag != rule_tag)
			report_mismatch("tag", 32'(rule_tag), 32'(o_fetch.tag));
		if (o_fetch.pc != rule_pc)
			report_mismatch("pc step", rule_pc, o_fetch.pc);
		if (o_fetch.pc != list_pc)
			report_mismatch("pc list", list_pc, o_fetch.pc);
		if (o_fetch.instruction != expected_word)
			report_mismatch("instruction", expected_word, o_fetch.instruction);

		// Direct-mapped lookup on the expected pc
		model_index = int'(list_pc[5:2]);
		if (model_valid[model_index] && model_tag[model_index] == list_pc[31:6]) begin
			model_hits++;
		end else begin
			model_misses++;
			model_valid[model_index] = 1'b1;
			model_tag[model_index] = list_pc[31:6];
		end

		opcode = expected_word[31:26];
		last_was_branch = (opcode == 6'h02) || (opcode == 6'h04);
		if (last_was_branch && branches_seen < int'(testdata[CFG_REDIRECTS])) begin
			branch_tag = o_fetch.tag;
			branch_target = testdata[TARGET_BASE + branches_seen];
			branches_seen++;
		end
		last_rule_pc = rule_pc;
		issue_count++;
	endtask

	always @(negedge i_clock) begin
		if (i_reset) begin
			prev_fetch = o_fetch;
		end else begin
			if (o_fetch != prev_fetch) begin
				if (prev_stall)
					report_problem("issued bundle changed while stall was high");
				if (o_fetch.tag != prev_fetch.tag)
					check_issue();
				else
					report_problem("issued bundle changed without a new tag");
			end
			if (o_bus_request && !prev_request) begin
				bus_request_count++;
				// A miss fetches the word of the next expected issue
				if (issue_count < n_issues &&
					o_bus_address != testdata[PC_BASE + issue_count])
					report_mismatch("bus address", testdata[PC_BASE + issue_count],
						o_bus_address);
			end
			prev_fetch = o_fetch;
			last_tag = o_fetch.tag;
		end
		prev_stall = i_stall;
		prev_request = o_bus_request;
		sampled_address = o_bus_address;
	end

	// Stall, redirect and bus memory stimulus
	logic [31:0] lcg_state = 32'h7f29;
	int mem_count = 0;
	logic mem_done = 1'b0;
	int delay_count = 0;
	logic holding = 1'b0;
	int hold_issue = 0;

	always @(posedge i_clock) begin
		if (i_reset) begin
			i_stall <= 1'b0;
			i_bus_ready <= 1'b0;
			i_redirect <= '{tag: 4'h8, pc_next: 32'h0};
		end else begin
			lcg_state <= lcg_next(lcg_state);
			i_stall <= (testdata[CFG_STALL] != 0) && (lcg_state[17:16] == 2'b00);

			if (holding) begin
				if (issue_count != hold_issue)
					holding <= 1'b0;
			end else if (branches_served < branches_seen) begin
				if (delay_count >= int'(testdata[CFG_DELAY])) begin
					i_redirect <= '{tag: branch_tag, pc_next: branch_target};
					holding <= 1'b1;
					hold_issue <= issue_count;
					branches_served <= branches_served + 1;
					delay_count <= 0;
				end else begin
					delay_count <= delay_count + 1;
				end
			end else begin
				// Idle tag never matches the instruction on display
				i_redirect <= '{tag: last_tag ^ 4'h8, pc_next: 32'h0};
			end

			i_bus_ready <= 1'b0;
			if (mem_done) begin
				if (!prev_request)
					mem_done <= 1'b0;
			end else if (prev_request) begin
				if (mem_count + 1 >= int'(testdata[CFG_LATENCY])) begin
					i_bus_ready <= 1'b1;
					i_bus_rdata <= mem_word(sampled_address);
					mem_done <= 1'b1;
					mem_count <= 0;
				end else begin
					mem_count <= mem_count + 1;
				end
			end
		end
	end

	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			testdata[MEM_BASE + i] = 32'hfc00_0000 | 32'(i << 2);
		for (int i = 0; i < 16; i++)
			model_valid[i] = 1'b0;
		$readmemh("test/testdata_fetch.txt", testdata);
		n_issues = int'(testdata[CFG_ISSUES]);

		repeat (8) @(posedge i_clock);
		i_reset <= 1'b0;

		while (issue_count < n_issues)
			@(negedge i_clock);
		// Give a stray issue or fill time to show up
		repeat (20) @(negedge i_clock);

		if (o_hit_count != 32'(model_hits))
			report_mismatch("hit count", 32'(model_hits), o_hit_count);
		if (o_miss_count != 32'(model_misses))
			report_mismatch("miss count", 32'(model_misses), o_miss_count);
		if (bus_request_count != model_misses)
			report_mismatch("bus requests", 32'(model_misses), 32'(bus_request_count));

		$display("issues %0d hits %0d misses %0d errors %0d",
			issue_count, o_hit_count, o_miss_count, error_count);
		if (error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog scaled by the expected number of issues
	initial begin
		#1;
		#(longint'(n_issues) * 200 * 100);
		$display("watchdog expired after %0d of %0d issues", issue_count, n_issues);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: test/testdata_fetch.txt
// Config at @00: bus latency, stall enable, issue count, redirect delay, redirect count
// @10 redirect targets in branch order, @20 expected issue pcs, @40 program words
@00
00000003
00000001
00000015
00000002
00000005
@10
00000004
00000040
00000000
00000040
00000020
@20
00000000
00000004
00000008
0000000c
00000010
00000004
00000008
0000000c
00000010
00000040
00000044
00000000
00000004
00000008
0000000c
00000010
00000040
00000044
00000020
00000024
00000028
// Program at byte address 0, branch at 0x10, jumps at 0x28 and 0x44
@40
20000000
20000004
20000008
2000000c
10000010
@48
20000020
20000024
08000028
@50
20000040
08000044

// File: all.f
logic/fetch_pkg.sv
logic/icache.sv
logic/fetch_unit.sv
logic/fetch_top.sv
test/fetch_assert.sv
test/tb_fetch.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fetch -f all.f -o tb_fetch

output=$(./obj_dir/tb_fetch)
echo "$output"

echo "$output" | grep -q "^TEST OK$"
